//--- common/tpu_config.svh
`ifndef TPU_CONFIG_SVH
`define TPU_CONFIG_SVH

//////////////////////////////
// queue geometry
//////////////////////////////

// number of issue-queue lines, kept even so the queue splits into two halves
`define TPU_ISQ_DEPTH 8
// width of the queue line index carried with each instruction
`define TPU_IDX_W 3

//////////////////////////////
// register file sizes
//////////////////////////////

// logical registers seen by the program
`define TPU_NUM_LREG 16
`define TPU_LREG_W 4
// physical register number width
`define TPU_PREG_W 6
// opaque control bits that ride along with each instruction
`define TPU_CTRL_W 16

`endif

//--- common/tpu_pkg.sv
`default_nettype none

package tpu_pkg;

  `include "tpu_config.svh"

  //////////////////////////////
  // register numbers
  //////////////////////////////

  typedef logic [`TPU_LREG_W-1:0] lreg_t;
  typedef logic [`TPU_PREG_W-1:0] preg_t;

  // one map entry, also used for a physical source or a freed register
  typedef struct packed {
    logic  vld;
    preg_t preg;
  } map_ent_t;

  // whole logical-to-physical map, entry n belongs to logical register n
  typedef map_ent_t [`TPU_NUM_LREG-1:0] reg_map_t;

  //////////////////////////////
  // queue line formats
  //////////////////////////////

  // one issue-queue line as it comes in from the queue
  typedef struct packed {
    logic [`TPU_IDX_W-1:0]  idx;
    logic                   inst_vld;
    logic                   lsrc1_vld;
    lreg_t                  lsrc1;
    logic                   ldst_vld;
    lreg_t                  ldst;
    logic                   lsrc2_vld;
    lreg_t                  lsrc2;
    logic [`TPU_CTRL_W-1:0] ctrl;
    // physical destination, allocated before the line enters the queue
    preg_t                  pdest;
  } isq_lin_t;

  // one renamed instruction, logical sources replaced by physical ones
  typedef struct packed {
    logic [`TPU_IDX_W-1:0]  idx;
    logic                   inst_vld;
    map_ent_t               psrc1;
    map_ent_t               psrc2;
    logic                   ldst_vld;
    logic [`TPU_CTRL_W-1:0] ctrl;
    preg_t                  pdest;
  } tpu_inst_t;

  // identity map: logical n sits in physical n, all entries valid
  function automatic reg_map_t ident_map();
    reg_map_t m;
    for (int n = 0; n < `TPU_NUM_LREG; n++) begin
      m[n].vld  = 1'b1;
      m[n].preg = preg_t'(n);
    end
    return m;
  endfunction

endpackage

`default_nettype wire

//--- tpu/tpu_lin.sv
`default_nettype none
`timescale 1ns/100ps

`include "tpu_config.svh"

// one rename line of the tag processing unit
// reads the map left by the line before, renames both sources,
// writes its own destination and hands the map on to the next line
module tpu_lin (
  input  wire logic               clk,
  input  wire logic               rst_n,
  // issue-queue line held in this slot
  input  wire tpu_pkg::isq_lin_t  isq_lin_i,
  // map as left by the previous line (or a segment header)
  input  wire tpu_pkg::reg_map_t  prv_map_i,
  // destination-ready update from wakeup
  input  wire logic               dst_reg_rdy_i,
  input  wire logic               dst_rdy_reg_en_i,
  // map after this line's destination write
  output tpu_pkg::reg_map_t       cur_map_o,
  // renamed instruction
  output tpu_pkg::tpu_inst_t      tpu_out_o,
  // mapping displaced by the new destination
  output tpu_pkg::map_ent_t       fre_preg_o,
  output logic                    inst_rdy_o
);

  import tpu_pkg::*;

  // line writes a new mapping for its destination
  logic     dst_wr;
  // stored destination-ready flag
  logic     rdy_q;
  // source lookups before the valid qualifier
  map_ent_t src1_ent;
  map_ent_t src2_ent;

  assign dst_wr = isq_lin_i.inst_vld & isq_lin_i.ldst_vld;

  //////////////////////////////
  // source lookup
  //////////////////////////////

  // both sources read the incoming map, never this line's own write
  assign src1_ent = prv_map_i[isq_lin_i.lsrc1];
  assign src2_ent = prv_map_i[isq_lin_i.lsrc2];

  always_comb
  begin
    // fields that pass straight through
    tpu_out_o.idx      = isq_lin_i.idx;
    tpu_out_o.inst_vld = isq_lin_i.inst_vld;
    tpu_out_o.ldst_vld = isq_lin_i.ldst_vld;
    tpu_out_o.ctrl     = isq_lin_i.ctrl;
    tpu_out_o.pdest    = isq_lin_i.pdest;
    // unused source reads as an all-zero entry
    if (isq_lin_i.lsrc1_vld)
    begin
      tpu_out_o.psrc1 = src1_ent;
    end
    else
    begin
      tpu_out_o.psrc1 = '0;
    end
    if (isq_lin_i.lsrc2_vld)
    begin
      tpu_out_o.psrc2 = src2_ent;
    end
    else
    begin
      tpu_out_o.psrc2 = '0;
    end
  end

  //////////////////////////////
  // map update
  //////////////////////////////

  always_comb
  begin
    cur_map_o = prv_map_i;
    // new destination takes over the logical register
    if (dst_wr)
    begin
      cur_map_o[isq_lin_i.ldst].vld  = 1'b1;
      cur_map_o[isq_lin_i.ldst].preg = isq_lin_i.pdest;
    end
  end

  // old mapping of the destination is freed once this line retires
  assign fre_preg_o = dst_wr ? prv_map_i[isq_lin_i.ldst] : '0;

  //////////////////////////////
  // destination ready flag
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rdy_q <= 1'b0;
    end
    else if (dst_rdy_reg_en_i)
    begin
      rdy_q <= dst_reg_rdy_i;
    end
  end

  // empty slot never reports ready
  assign inst_rdy_o = rdy_q & isq_lin_i.inst_vld;

  // allocator must hand in a real pdest whenever the line writes the map
  a_pdest_known : assert property (
    @(posedge clk) disable iff (!rst_n)
    dst_wr |-> !$isunknown(isq_lin_i.pdest)
  );

endmodule

`default_nettype wire

//--- tpu/tpu_seg_hdr.sv
`default_nettype none
`timescale 1ns/100ps

`include "tpu_config.svh"

// segment headers of the rename chain
// holds the arch bit and one saved map per queue half,
// and picks the map that enters each half
module tpu_seg_hdr (
  input  wire logic              clk,
  input  wire logic              rst_n,
  // pulse, hands the head over to the other half
  input  wire logic              arch_swt_i,
  // map at the last line of the low half
  input  wire tpu_pkg::reg_map_t mid_tail_map_i,
  // map at the last line of the high half
  input  wire tpu_pkg::reg_map_t end_tail_map_i,
  // map entering line 0
  output tpu_pkg::reg_map_t      top_entry_map_o,
  // map entering line D/2
  output tpu_pkg::reg_map_t      mid_entry_map_o,
  output logic                   arch_o
);

  import tpu_pkg::*;

  // 0 means the low half holds the head of the queue
  logic     arch_q;
  // architectural map at the head of each half
  reg_map_t top_hdr_q;
  reg_map_t mid_hdr_q;
  // header load strobes
  logic     top_ld;
  logic     mid_ld;

  // the half that retires leaves its tail map as the new head state
  assign mid_ld = arch_swt_i & ~arch_q;
  assign top_ld = arch_swt_i & arch_q;

  //////////////////////////////
  // arch bit and headers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      arch_q <= 1'b0;
    end
    else if (arch_swt_i)
    begin
      arch_q <= ~arch_q;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      top_hdr_q <= ident_map();
      mid_hdr_q <= ident_map();
    end
    else
    begin
      if (top_ld)
      begin
        top_hdr_q <= end_tail_map_i;
      end
      if (mid_ld)
      begin
        mid_hdr_q <= mid_tail_map_i;
      end
    end
  end

  // head half starts from its header, the other half continues the chain
  assign top_entry_map_o = arch_q ? end_tail_map_i : top_hdr_q;
  assign mid_entry_map_o = arch_q ? mid_hdr_q : mid_tail_map_i;
  assign arch_o          = arch_q;

  a_swt_known : assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown(arch_swt_i)
  );

  // header of the new head half holds the tail map seen at the switch
  a_hdr_follows_arch : assert property (
    @(posedge clk) disable iff (!rst_n)
    arch_swt_i |=> (arch_q ? (mid_hdr_q == $past(mid_tail_map_i))
                           : (top_hdr_q == $past(end_tail_map_i)))
  );

endmodule

`default_nettype wire

//--- tpu/tpu_reorder.sv
`default_nettype none
`timescale 1ns/100ps

`include "tpu_config.svh"

// output rotation, the older half of the queue always lands on the low lines
module tpu_reorder (
  input  wire logic                       arch_i,
  // per-line results in queue order
  input  wire tpu_pkg::tpu_inst_t         raw_inst_i [`TPU_ISQ_DEPTH],
  input  wire tpu_pkg::map_ent_t          raw_fre_i  [`TPU_ISQ_DEPTH],
  input  wire logic [`TPU_ISQ_DEPTH-1:0]  raw_rdy_i,
  // same results in age order
  output tpu_pkg::tpu_inst_t              inst_o [`TPU_ISQ_DEPTH],
  output tpu_pkg::map_ent_t               fre_o  [`TPU_ISQ_DEPTH],
  output logic [`TPU_ISQ_DEPTH-1:0]       rdy_o
);

  localparam int unsigned DEPTH = `TPU_ISQ_DEPTH;
  localparam int unsigned HALF  = DEPTH / 2;

  //////////////////////////////
  // half-queue rotation
  //////////////////////////////

  // arch 0 keeps queue order, arch 1 swaps the halves
  for (genvar k = 0; k < DEPTH; k++)
  begin : g_rot
    // raw line that moves to output k when the high half is the head
    localparam int unsigned SRC = (k + HALF) % DEPTH;

    assign inst_o[k] = arch_i ? raw_inst_i[SRC] : raw_inst_i[k];
    assign fre_o[k]  = arch_i ? raw_fre_i[SRC] : raw_fre_i[k];
    // ready bits follow their instruction
    assign rdy_o[k]  = arch_i ? raw_rdy_i[SRC] : raw_rdy_i[k];
  end

endmodule

`default_nettype wire

//--- tpu/tpu.sv
`default_nettype none
`timescale 1ns/100ps

`include "tpu_config.svh"

// tag processing unit, renames every issue-queue line in one cycle
// lines form a map chain that is cut at the two segment heads
module tpu (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire tpu_pkg::isq_lin_t          isq_lin_i [`TPU_ISQ_DEPTH],
  input  wire logic [`TPU_ISQ_DEPTH-1:0]  dst_reg_rdy_i,
  input  wire logic [`TPU_ISQ_DEPTH-1:0]  dst_rdy_reg_en_i,
  // switch the head to the other half
  input  wire logic                       arch_swt_i,
  // renamed lines, oldest half first
  output tpu_pkg::tpu_inst_t              tpu_out_o [`TPU_ISQ_DEPTH],
  output tpu_pkg::map_ent_t               fre_preg_o [`TPU_ISQ_DEPTH],
  output logic [`TPU_ISQ_DEPTH-1:0]       tpu_inst_rdy_o
);

  import tpu_pkg::*;

  localparam int unsigned DEPTH = `TPU_ISQ_DEPTH;
  localparam int unsigned HALF  = DEPTH / 2;

  // map into and out of every line
  reg_map_t              prv_map [DEPTH];
  reg_map_t              cur_map [DEPTH];
  // maps entering the two segment heads
  reg_map_t              top_entry_map;
  reg_map_t              mid_entry_map;
  // per-line results before the rotation
  tpu_inst_t             raw_inst [DEPTH];
  map_ent_t              raw_fre [DEPTH];
  logic [DEPTH-1:0]      raw_rdy;
  logic                  arch;

  // two equal halves are needed for the segment split
  if (DEPTH % 2 != 0)
  begin : g_depth_chk
    $error("queue depth must be even");
  end

  //////////////////////////////
  // rename chain
  //////////////////////////////

  for (genvar k = 0; k < DEPTH; k++)
  begin : g_lin
    // chain is cut at line 0 and line D/2
    if (k == 0)
    begin : g_top
      assign prv_map[k] = top_entry_map;
    end
    else if (k == HALF)
    begin : g_mid
      assign prv_map[k] = mid_entry_map;
    end
    else
    begin : g_chain
      assign prv_map[k] = cur_map[k-1];
    end

    tpu_lin i_lin (
      .clk              (clk),
      .rst_n            (rst_n),
      .isq_lin_i        (isq_lin_i[k]),
      .prv_map_i        (prv_map[k]),
      .dst_reg_rdy_i    (dst_reg_rdy_i[k]),
      .dst_rdy_reg_en_i (dst_rdy_reg_en_i[k]),
      .cur_map_o        (cur_map[k]),
      .tpu_out_o        (raw_inst[k]),
      .fre_preg_o       (raw_fre[k]),
      .inst_rdy_o       (raw_rdy[k])
    );
  end

  // headers see the tail map of each half
  tpu_seg_hdr i_seg_hdr (
    .clk             (clk),
    .rst_n           (rst_n),
    .arch_swt_i      (arch_swt_i),
    .mid_tail_map_i  (cur_map[HALF-1]),
    .end_tail_map_i  (cur_map[DEPTH-1]),
    .top_entry_map_o (top_entry_map),
    .mid_entry_map_o (mid_entry_map),
    .arch_o          (arch)
  );

  tpu_reorder i_reorder (
    .arch_i     (arch),
    .raw_inst_i (raw_inst),
    .raw_fre_i  (raw_fre),
    .raw_rdy_i  (raw_rdy),
    .inst_o     (tpu_out_o),
    .fre_o      (fre_preg_o),
    .rdy_o      (tpu_inst_rdy_o)
  );

endmodule

`default_nettype wire

//--- dv/tb_clk.sv
`default_nettype none
`timescale 1ns/100ps

// free-running testbench clock
module tb_clk #(
  parameter int unsigned PERIOD_NS = 100
) (
  output logic clk_o
);

  // low first, so the first rising edge comes half a period in
  initial
  begin
    clk_o = 1'b0;
  end

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- dv/tb_tpu.sv
`default_nettype none
`timescale 1ns/100ps

`include "tpu_config.svh"

module tb_tpu;

  import tpu_pkg::*;

  localparam int unsigned DEPTH     = `TPU_ISQ_DEPTH;
  localparam int unsigned HALF      = DEPTH / 2;
  localparam int unsigned CLK_NS    = 100;
  localparam int unsigned SETTLE_NS = 10;
  // at most 200 cycles for each of the 5 tests
  localparam int unsigned LIMIT_NS  = 5 * 200 * CLK_NS;

  logic                 clk;
  logic                 rst_n;
  isq_lin_t             isq_lin [DEPTH];
  logic [DEPTH-1:0]     dst_reg_rdy;
  logic [DEPTH-1:0]     dst_rdy_reg_en;
  logic                 arch_swt;
  tpu_inst_t            tpu_out [DEPTH];
  map_ent_t             fre_preg [DEPTH];
  logic [DEPTH-1:0]     tpu_inst_rdy;

  // reference arch bit, both headers and the per-line ready flags
  logic                 m_arch;
  reg_map_t             m_top_hdr;
  reg_map_t             m_mid_hdr;
  logic [DEPTH-1:0]     m_rdy;
  // predicted outputs in age order and the two tail maps
  tpu_inst_t            exp_inst [DEPTH];
  map_ent_t             exp_fre [DEPTH];
  logic [DEPTH-1:0]     exp_rdy;
  reg_map_t             mid_tail;
  reg_map_t             end_tail;

  tb_clk #(.PERIOD_NS(CLK_NS)) i_clk (.clk_o(clk));

  tpu i_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .isq_lin_i        (isq_lin),
    .dst_reg_rdy_i    (dst_reg_rdy),
    .dst_rdy_reg_en_i (dst_rdy_reg_en),
    .arch_swt_i       (arch_swt),
    .tpu_out_o        (tpu_out),
    .fre_preg_o       (fre_preg),
    .tpu_inst_rdy_o   (tpu_inst_rdy)
  );

  //////////////////////////////
  // failure reporting
  //////////////////////////////

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_inst(input string name, input tpu_inst_t exp, input tpu_inst_t act);
    if (act !== exp)
    begin
      stop_on_error($sformatf("FAIL %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_ent(input string name, input map_ent_t exp, input map_ent_t act);
    if (act !== exp)
    begin
      stop_on_error($sformatf("FAIL %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_rdy(input string name, input logic [DEPTH-1:0] exp,
                           input logic [DEPTH-1:0] act);
    if (act !== exp)
    begin
      stop_on_error($sformatf("FAIL %s expected %h actual %h", name, exp, act));
    end
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic reg_map_t identity_map();
    reg_map_t m;
    for (int n = 0; n < `TPU_NUM_LREG; n++)
    begin
      m[n] = '{vld: 1'b1, preg: preg_t'(n)};
    end
    return m;
  endfunction

  // rename one line against map m and leave the updated map in m
  function automatic void rename_line(input isq_lin_t l, inout reg_map_t m,
                                      output tpu_inst_t o, output map_ent_t f);
    o.idx      = l.idx;
    o.inst_vld = l.inst_vld;
    o.ldst_vld = l.ldst_vld;
    o.ctrl     = l.ctrl;
    o.pdest    = l.pdest;
    o.psrc1    = l.lsrc1_vld ? m[l.lsrc1] : '0;
    o.psrc2    = l.lsrc2_vld ? m[l.lsrc2] : '0;
    f          = '0;
    if (l.inst_vld && l.ldst_vld)
    begin
      f         = m[l.ldst];
      m[l.ldst] = '{vld: 1'b1, preg: l.pdest};
    end
  endfunction

  // walk the chain from the head half, then rotate into age order
  task automatic predict_outputs();
    reg_map_t  map;
    tpu_inst_t raw_inst [DEPTH];
    map_ent_t  raw_fre [DEPTH];
    int        start;
    int        k;
    int        src;
    map   = m_arch ? m_mid_hdr : m_top_hdr;
    start = m_arch ? HALF : 0;
    for (int i = 0; i < DEPTH; i++)
    begin
      k = (start + i) % DEPTH;
      rename_line(isq_lin[k], map, raw_inst[k], raw_fre[k]);
      if (k == HALF - 1)
      begin
        mid_tail = map;
      end
      if (k == DEPTH - 1)
      begin
        end_tail = map;
      end
    end
    for (int j = 0; j < DEPTH; j++)
    begin
      src         = m_arch ? (j + HALF) % DEPTH : j;
      exp_inst[j] = raw_inst[src];
      exp_fre[j]  = raw_fre[src];
      exp_rdy[j]  = m_rdy[src] & isq_lin[src].inst_vld;
    end
  endtask

  task automatic compare_outputs();
    predict_outputs();
    for (int j = 0; j < DEPTH; j++)
    begin
      check_inst($sformatf("tpu_out_o[%0d]", j), exp_inst[j], tpu_out[j]);
      check_ent($sformatf("fre_preg_o[%0d]", j), exp_fre[j], fre_preg[j]);
    end
    check_rdy("tpu_inst_rdy_o", exp_rdy, tpu_inst_rdy);
  endtask

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  function automatic isq_lin_t random_line(input int k);
    isq_lin_t l;
    l.idx       = k[`TPU_IDX_W-1:0];
    l.inst_vld  = 1'b1;
    l.lsrc1_vld = 1'b1;
    l.lsrc1     = lreg_t'($urandom);
    l.ldst_vld  = 1'b1;
    l.ldst      = lreg_t'($urandom);
    l.lsrc2_vld = 1'b1;
    l.lsrc2     = lreg_t'($urandom);
    l.ctrl      = `TPU_CTRL_W'($urandom);
    // keep pdest above the identity range so renamed values stand out
    l.pdest     = preg_t'($urandom_range(`TPU_NUM_LREG, (1 << `TPU_PREG_W) - 1));
    return l;
  endfunction

  task automatic fill_random();
    for (int k = 0; k < DEPTH; k++)
    begin
      isq_lin[k] = random_line(k);
    end
  endtask

  // one-cycle switch pulse with the model headers following the retiring tail
  task automatic pulse_arch_switch();
    @(negedge clk);
    arch_swt = 1'b1;
    #(SETTLE_NS);
    compare_outputs();
    if (!m_arch)
    begin
      m_mid_hdr = mid_tail;
    end
    else
    begin
      m_top_hdr = end_tail;
    end
    m_arch = ~m_arch;
    @(negedge clk);
    arch_swt = 1'b0;
    #(SETTLE_NS);
    compare_outputs();
  endtask

  // random ready bits under random enables are checked one cycle later
  task automatic load_ready();
    @(negedge clk);
    dst_reg_rdy    = DEPTH'($urandom);
    dst_rdy_reg_en = DEPTH'($urandom);
    for (int k = 0; k < DEPTH; k++)
    begin
      isq_lin[k].inst_vld = $urandom_range(0, 3) != 0;
      if (dst_rdy_reg_en[k])
      begin
        m_rdy[k] = dst_reg_rdy[k];
      end
    end
    @(negedge clk);
    dst_rdy_reg_en = '0;
    #(SETTLE_NS);
    compare_outputs();
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic reset_state();
    @(negedge clk);
    for (int k = 0; k < DEPTH; k++)
    begin
      isq_lin[k] = '0;
    end
    isq_lin[0] = '{idx: '0, inst_vld: 1'b1, lsrc1_vld: 1'b1, lsrc1: lreg_t'(5),
                   ldst_vld: 1'b1, ldst: lreg_t'(3), lsrc2_vld: 1'b1,
                   lsrc2: lreg_t'(9), ctrl: '0, pdest: preg_t'(40)};
    #(SETTLE_NS);
    check_rdy("tpu_inst_rdy_o", '0, tpu_inst_rdy);
    check_ent("tpu_out_o[0].psrc1", '{vld: 1'b1, preg: preg_t'(5)}, tpu_out[0].psrc1);
    check_ent("tpu_out_o[0].psrc2", '{vld: 1'b1, preg: preg_t'(9)}, tpu_out[0].psrc2);
    check_ent("fre_preg_o[0]", '{vld: 1'b1, preg: preg_t'(3)}, fre_preg[0]);
    compare_outputs();
  endtask

  task automatic chained_rename();
    for (int r = 0; r < 20; r++)
    begin
      @(negedge clk);
      fill_random();
      // line 1 reads what line 0 just wrote
      isq_lin[1].lsrc1 = isq_lin[0].ldst;
      #(SETTLE_NS);
      check_ent("tpu_out_o[1].psrc1", '{vld: 1'b1, preg: isq_lin[0].pdest},
                tpu_out[1].psrc1);
      compare_outputs();
    end
  endtask

  task automatic invalid_fields();
    for (int r = 0; r < 20; r++)
    begin
      @(negedge clk);
      fill_random();
      isq_lin[2].inst_vld  = 1'b0;
      isq_lin[3].ldst_vld  = 1'b0;
      isq_lin[4].lsrc1_vld = 1'b0;
      isq_lin[4].lsrc2_vld = 1'b0;
      // a later line reads the register the dropped writes aimed at
      isq_lin[5].lsrc1     = isq_lin[2].ldst;
      isq_lin[5].lsrc2     = isq_lin[3].ldst;
      #(SETTLE_NS);
      check_ent("fre_preg_o[2]", '0, fre_preg[2]);
      check_ent("fre_preg_o[3]", '0, fre_preg[3]);
      check_ent("tpu_out_o[4].psrc1", '0, tpu_out[4].psrc1);
      check_ent("tpu_out_o[4].psrc2", '0, tpu_out[4].psrc2);
      compare_outputs();
    end
  endtask

  task automatic arch_switch();
    @(negedge clk);
    fill_random();
    #(SETTLE_NS);
    compare_outputs();
    // same lines across the switch, so the snapshot is visible at line D/2
    pulse_arch_switch();
    @(negedge clk);
    fill_random();
    #(SETTLE_NS);
    compare_outputs();
    pulse_arch_switch();
  endtask

  task automatic ready_flags();
    @(negedge clk);
    fill_random();
    for (int r = 0; r < 10; r++)
    begin
      load_ready();
    end
    pulse_arch_switch();
    for (int r = 0; r < 10; r++)
    begin
      load_ready();
    end
  endtask

  //////////////////////////////
  // main sequence and watchdog
  //////////////////////////////

  initial
  begin
    void'($urandom(32'h289e));
    rst_n          = 1'b0;
    dst_reg_rdy    = '0;
    dst_rdy_reg_en = '0;
    arch_swt       = 1'b0;
    for (int k = 0; k < DEPTH; k++)
    begin
      isq_lin[k] = '0;
    end
    m_arch    = 1'b0;
    m_top_hdr = identity_map();
    m_mid_hdr = identity_map();
    m_rdy     = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    reset_state();
    chained_rename();
    invalid_fields();
    arch_switch();
    ready_flags();
    $display("Done: no errors");
    $finish;
  end

  initial
  begin
    #(LIMIT_NS);
    stop_on_error("timeout: the tests did not finish in the allowed time");
  end

endmodule

`default_nettype wire

//--- tpu.f
+incdir+common
common/tpu_pkg.sv
tpu/tpu_lin.sv
tpu/tpu_seg_hdr.sv
tpu/tpu_reorder.sv
tpu/tpu.sv
dv/tb_clk.sv
dv/tb_tpu.sv

//--- Makefile
# Verilator build of the tpu testbench
# the run target fails whenever the testbench stops with $fatal

OBJ_DIR := obj_dir

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal \
		-f tpu.f --top-module tb_tpu \
		-Mdir $(OBJ_DIR) -o Vtb_tpu

run: compile
	./$(OBJ_DIR)/Vtb_tpu

clean:
	rm -rf $(OBJ_DIR)
